/* logic/bht_consts.svh */
`ifndef BHT_CONSTS_SVH
`define BHT_CONSTS_SVH

// instruction address and target width
`define BHT_PC_W      12

// table size, fully associative
`define BHT_WAYS      8
`define BHT_WAY_IDX_W 3

// saturating age, 4 bits is enough to order 8 ways
`define BHT_AGE_W     4

`endif

/* logic/bht_addr_pkg.sv */
`default_nettype none

`include "bht_consts.svh"

package bht_addr_pkg;

    // fetch address or branch target
    typedef logic [`BHT_PC_W-1:0] pc_t;

endpackage

`default_nettype wire

/* logic/bht_entry_pkg.sv */
`default_nettype none

`include "bht_consts.svh"

package bht_entry_pkg;

    // two-bit direction state, msb set means predict taken
    typedef enum logic [1:0] {
        CNT_STRONG_NT = 2'b00,
        CNT_WEAK_NT   = 2'b01,
        CNT_WEAK_T    = 2'b10,
        CNT_STRONG_T  = 2'b11
    } counter_t;

    // updates since last touch, saturating
    typedef logic [`BHT_AGE_W-1:0] age_t;

    // entry number
    typedef logic [`BHT_WAY_IDX_W-1:0] way_idx_t;

    // one bit per entry
    typedef logic [`BHT_WAYS-1:0] way_mask_t;

endpackage

`default_nettype wire

/* logic/bht_update_match.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bht_consts.svh"

module bht_update_match (
    input  wire logic                      i_upd_valid,
    input  wire bht_addr_pkg::pc_t         i_upd_pc,
    input  wire bht_entry_pkg::way_mask_t  i_entry_valid,
    input  wire bht_addr_pkg::pc_t         i_entry_pc [`BHT_WAYS],
    output bht_entry_pkg::way_mask_t       o_hit_mask,
    output logic                           o_alloc
);

    ////////////////////////////////////////////////////////////////////////////
    // address compare against every stored branch
    ////////////////////////////////////////////////////////////////////////////

    bht_entry_pkg::way_mask_t addr_match;

    always_comb begin
        for (int w = 0; w < `BHT_WAYS; w++) begin
            addr_match[w] = i_entry_valid[w] && (i_entry_pc[w] == i_upd_pc);
        end
    end

    // only a resolved branch counts
    assign o_hit_mask = i_upd_valid ? addr_match : '0;

    // miss on a real update, fill the oldest way
    assign o_alloc = i_upd_valid && !(|addr_match);

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // a branch is only ever allocated once, so two hits mean the
    // table and the victim logic disagree about what is stored
    always_comb begin
        assert final ($onehot0(o_hit_mask))
            else $error("update hit more than one way: %b", o_hit_mask);
    end

endmodule

`default_nettype wire

/* logic/bht_victim_select.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bht_consts.svh"

module bht_victim_select (
    input  wire bht_entry_pkg::age_t  i_entry_age [`BHT_WAYS],
    output bht_entry_pkg::way_idx_t   o_victim
);

    // pairwise tree, 8 -> 4 -> 2 -> 1
    bht_entry_pkg::way_idx_t l1_idx [4];
    bht_entry_pkg::age_t     l1_age [4];
    bht_entry_pkg::way_idx_t l2_idx [2];
    bht_entry_pkg::age_t     l2_age [2];
    bht_entry_pkg::age_t     victim_age;

    always_comb begin
        // first level, neighbours
        for (int n = 0; n < 4; n++) begin
            if (i_entry_age[2*n] >= i_entry_age[2*n+1]) begin
                l1_idx[n] = bht_entry_pkg::way_idx_t'(2*n);
                l1_age[n] = i_entry_age[2*n];
            end else begin
                l1_idx[n] = bht_entry_pkg::way_idx_t'(2*n+1);
                l1_age[n] = i_entry_age[2*n+1];
            end
        end

        // second level, left wins ties again
        for (int n = 0; n < 2; n++) begin
            if (l1_age[2*n] >= l1_age[2*n+1]) begin
                l2_idx[n] = l1_idx[2*n];
                l2_age[n] = l1_age[2*n];
            end else begin
                l2_idx[n] = l1_idx[2*n+1];
                l2_age[n] = l1_age[2*n+1];
            end
        end

        // root
        if (l2_age[0] >= l2_age[1]) begin
            o_victim   = l2_idx[0];
            victim_age = l2_age[0];
        end else begin
            o_victim   = l2_idx[1];
            victim_age = l2_age[1];
        end
    end

    // the tree has to land on a true maximum
    logic age_ok;

    always_comb begin
        age_ok = 1'b1;
        for (int w = 0; w < `BHT_WAYS; w++) begin
            if (victim_age < i_entry_age[w]) age_ok = 1'b0;
        end
        assert final (age_ok)
            else $error("victim way %0d is not the oldest", o_victim);
    end

endmodule

`default_nettype wire

/* logic/bht_entry_table.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bht_consts.svh"

module bht_entry_table (
    input  wire logic                      clk,
    input  wire logic                      i_arst_n,
    input  wire bht_entry_pkg::way_mask_t  i_hit_mask,
    input  wire logic                      i_alloc,
    input  wire bht_entry_pkg::way_idx_t   i_victim,
    input  wire bht_addr_pkg::pc_t         i_upd_pc,
    input  wire bht_addr_pkg::pc_t         i_upd_target,
    input  wire logic                      i_upd_taken,
    output bht_entry_pkg::way_mask_t       o_entry_valid,
    output bht_addr_pkg::pc_t              o_entry_pc [`BHT_WAYS],
    output bht_addr_pkg::pc_t              o_entry_target [`BHT_WAYS],
    output bht_entry_pkg::counter_t        o_entry_counter [`BHT_WAYS],
    output bht_entry_pkg::age_t            o_entry_age [`BHT_WAYS]
);

    ////////////////////////////////////////////////////////////////////////////
    // entry state
    ////////////////////////////////////////////////////////////////////////////

    bht_entry_pkg::way_mask_t entry_valid;
    bht_addr_pkg::pc_t        entry_pc      [`BHT_WAYS];
    bht_addr_pkg::pc_t        entry_target  [`BHT_WAYS];
    bht_entry_pkg::counter_t  entry_counter [`BHT_WAYS];
    bht_entry_pkg::age_t      entry_age     [`BHT_WAYS];

    // any update touches exactly one way this cycle
    logic upd_any;

    assign upd_any = (|i_hit_mask) || i_alloc;

    // saturating step toward the resolved direction
    function automatic bht_entry_pkg::counter_t train(
        input bht_entry_pkg::counter_t cnt,
        input logic                    taken
    );
        bht_entry_pkg::counter_t nxt;
        nxt = cnt;
        if (taken) begin
            if (cnt != bht_entry_pkg::CNT_STRONG_T) begin
                nxt = bht_entry_pkg::counter_t'(cnt + 2'd1);
            end
        end else begin
            if (cnt != bht_entry_pkg::CNT_STRONG_NT) begin
                nxt = bht_entry_pkg::counter_t'(cnt - 2'd1);
            end
        end
        return nxt;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // training, allocation and aging
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int w = 0; w < `BHT_WAYS; w++) begin
                entry_valid[w]   <= 1'b0;
                entry_pc[w]      <= '0;
                entry_target[w]  <= '0;
                entry_counter[w] <= bht_entry_pkg::CNT_WEAK_T;
                entry_age[w]     <= '0;
            end
        end else begin
            for (int w = 0; w < `BHT_WAYS; w++) begin
                if (i_hit_mask[w]) begin
                    // known branch, target kept as stored
                    entry_counter[w] <= train(entry_counter[w], i_upd_taken);
                    entry_age[w]     <= '0;
                end else if (i_alloc && (i_victim == bht_entry_pkg::way_idx_t'(w))) begin
                    // new branch always starts weak not taken
                    entry_valid[w]   <= 1'b1;
                    entry_pc[w]      <= i_upd_pc;
                    entry_target[w]  <= i_upd_target;
                    entry_counter[w] <= bht_entry_pkg::CNT_WEAK_NT;
                    entry_age[w]     <= '0;
                end else if (upd_any) begin
                    if (entry_age[w] != '1) begin
                        entry_age[w] <= entry_age[w] + 1'b1;
                    end
                end
            end
        end
    end

    assign o_entry_valid   = entry_valid;
    assign o_entry_pc      = entry_pc;
    assign o_entry_target  = entry_target;
    assign o_entry_counter = entry_counter;
    assign o_entry_age     = entry_age;

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // the match logic must never ask for a fill and a train at once
    a_alloc_xor_hit : assert property (
        @(posedge clk) disable iff (!i_arst_n)
        !(i_alloc && (|i_hit_mask))
    ) else $error("allocation requested together with a hit");

endmodule

`default_nettype wire

/* logic/bht_predict_select.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bht_consts.svh"

module bht_predict_select (
    input  wire bht_addr_pkg::pc_t         i_query_pc,
    input  wire bht_entry_pkg::way_mask_t  i_entry_valid,
    input  wire bht_addr_pkg::pc_t         i_entry_pc [`BHT_WAYS],
    input  wire bht_addr_pkg::pc_t         i_entry_target [`BHT_WAYS],
    input  wire bht_entry_pkg::counter_t   i_entry_counter [`BHT_WAYS],
    output logic                           o_pred_taken,
    output bht_addr_pkg::pc_t              o_pred_target
);

    ////////////////////////////////////////////////////////////////////////////
    // query match
    ////////////////////////////////////////////////////////////////////////////

    bht_entry_pkg::way_mask_t query_match;
    bht_entry_pkg::way_mask_t taken_mask;

    always_comb begin
        for (int w = 0; w < `BHT_WAYS; w++) begin
            query_match[w] = i_entry_valid[w] && (i_entry_pc[w] == i_query_pc);
            // counter msb is the taken half of the state space
            taken_mask[w]  = query_match[w] && i_entry_counter[w][1];
        end
    end

    assign o_pred_taken = |taken_mask;

    ////////////////////////////////////////////////////////////////////////////
    // target select
    ////////////////////////////////////////////////////////////////////////////

    // and-or mux, zero when nothing predicts taken
    always_comb begin
        o_pred_target = '0;
        for (int w = 0; w < `BHT_WAYS; w++) begin
            o_pred_target = o_pred_target | ({`BHT_PC_W{taken_mask[w]}} & i_entry_target[w]);
        end
    end

    // the and-or mux only works if at most one way matches
    always_comb begin
        assert final ($onehot0(query_match))
            else $error("query %h matched several ways: %b", i_query_pc, query_match);
    end

endmodule

`default_nettype wire

/* logic/bht_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bht_consts.svh"

module bht_top (
    input  wire logic               clk,
    input  wire logic               i_arst_n,
    input  wire bht_addr_pkg::pc_t  i_query_pc,
    input  wire logic               i_upd_valid,
    input  wire bht_addr_pkg::pc_t  i_upd_pc,
    input  wire bht_addr_pkg::pc_t  i_upd_target,
    input  wire logic               i_upd_taken,
    output logic                    o_pred_taken,
    output bht_addr_pkg::pc_t       o_pred_target
);

    // table contents
    bht_entry_pkg::way_mask_t entry_valid;
    bht_addr_pkg::pc_t        entry_pc      [`BHT_WAYS];
    bht_addr_pkg::pc_t        entry_target  [`BHT_WAYS];
    bht_entry_pkg::counter_t  entry_counter [`BHT_WAYS];
    bht_entry_pkg::age_t      entry_age     [`BHT_WAYS];

    // update control
    bht_entry_pkg::way_mask_t hit_mask;
    logic                     alloc;
    bht_entry_pkg::way_idx_t  victim;

    bht_update_match u_update_match (
        .i_upd_valid   (i_upd_valid),
        .i_upd_pc      (i_upd_pc),
        .i_entry_valid (entry_valid),
        .i_entry_pc    (entry_pc),
        .o_hit_mask    (hit_mask),
        .o_alloc       (alloc)
    );

    bht_victim_select u_victim_select (
        .i_entry_age (entry_age),
        .o_victim    (victim)
    );

    bht_entry_table u_entry_table (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_hit_mask      (hit_mask),
        .i_alloc         (alloc),
        .i_victim        (victim),
        .i_upd_pc        (i_upd_pc),
        .i_upd_target    (i_upd_target),
        .i_upd_taken     (i_upd_taken),
        .o_entry_valid   (entry_valid),
        .o_entry_pc      (entry_pc),
        .o_entry_target  (entry_target),
        .o_entry_counter (entry_counter),
        .o_entry_age     (entry_age)
    );

    bht_predict_select u_predict_select (
        .i_query_pc      (i_query_pc),
        .i_entry_valid   (entry_valid),
        .i_entry_pc      (entry_pc),
        .i_entry_target  (entry_target),
        .i_entry_counter (entry_counter),
        .o_pred_taken    (o_pred_taken),
        .o_pred_target   (o_pred_target)
    );

endmodule

`default_nettype wire

/* sim/bht_tb_checks.svh */
`ifndef BHT_TB_CHECKS_SVH
`define BHT_TB_CHECKS_SVH

    // result counters
    int tests_run    = 0;
    int tests_passed = 0;
    int check_errors = 0;
    // file, format and timeout problems
    int other_errors = 0;

    // predicted direction
    task automatic check_taken(
        input string name,
        input logic  expected,
        input logic  actual
    );
        if (actual !== expected) begin
            $display("FAILED %s: taken expected %0b, actual %0b", name, expected, actual);
            check_errors++;
        end
    endtask

    // predicted target, zero when not taken
    task automatic check_target(
        input string             name,
        input bht_addr_pkg::pc_t expected,
        input bht_addr_pkg::pc_t actual
    );
        if (actual !== expected) begin
            $display("FAILED %s: target expected %h, actual %h", name, expected, actual);
            check_errors++;
        end
    endtask

    // a query test is done once both compares ran
    task automatic report_test(
        input string name,
        input int    errs_before
    );
        tests_run++;
        if (check_errors == errs_before) begin
            tests_passed++;
            $display("ok     %s", name);
        end
    endtask

`endif

/* sim/bht_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module bht_tb;

    localparam int HALF_PERIOD   = 10;
    localparam int RESET_CYCLES  = 3;
    localparam int RESET_TIMEOUT = 20;
    localparam int RUN_TIMEOUT   = 2000;

    logic              clk;
    logic              i_arst_n;
    bht_addr_pkg::pc_t i_query_pc;
    logic              i_upd_valid;
    bht_addr_pkg::pc_t i_upd_pc;
    bht_addr_pkg::pc_t i_upd_target;
    logic              i_upd_taken;
    logic              o_pred_taken;
    bht_addr_pkg::pc_t o_pred_target;

    `include "bht_tb_checks.svh"

    bht_top i_dut (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_query_pc    (i_query_pc),
        .i_upd_valid   (i_upd_valid),
        .i_upd_pc      (i_upd_pc),
        .i_upd_target  (i_upd_target),
        .i_upd_taken   (i_upd_taken),
        .o_pred_taken  (o_pred_taken),
        .o_pred_target (o_pred_target)
    );

    initial clk = 1'b0;

    always #(HALF_PERIOD) clk = ~clk;

    // reset for a few cycles, released on a falling edge
    initial begin
        i_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        i_arst_n = 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // vector player
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int                fd;
        int                n_fields;
        int                cycles;
        int                errs_before;
        string             line;
        string             op;
        string             name;
        bht_addr_pkg::pc_t addr;
        bht_addr_pkg::pc_t target;
        logic              taken;
        logic              exp_taken;
        bht_addr_pkg::pc_t exp_target;

        i_query_pc   = '0;
        i_upd_valid  = 1'b0;
        i_upd_pc     = '0;
        i_upd_target = '0;
        i_upd_taken  = 1'b0;

        cycles = 0;
        while (i_arst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (i_arst_n !== 1'b1) begin
            $display("reset was not released within %0d cycles", RESET_TIMEOUT);
            other_errors++;
        end

        fd = $fopen("sim/bht_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file sim/bht_vectors.txt");
            other_errors++;
        end

        cycles = 0;
        while (fd != 0 && !$feof(fd) && cycles < RUN_TIMEOUT) begin
            line = "";
            void'($fgets(line, fd));
            n_fields = $sscanf(line, "%s %s %h %h %b %b %h",
                               op, name, addr, target, taken, exp_taken, exp_target);
            if (line.len() == 0 || line[0] == "#" || n_fields <= 0) begin
                // comment or blank line
            end else if (n_fields != 7) begin
                $display("vector line has %0d fields instead of 7: %0s", n_fields, line);
                other_errors++;
            end else begin
                @(negedge clk);
                cycles++;
                if (op == "U") begin
                    i_upd_valid  = 1'b1;
                    i_upd_pc     = addr;
                    i_upd_target = target;
                    i_upd_taken  = taken;
                end else if (op == "I") begin
                    // fields move but the update is not valid
                    i_upd_valid  = 1'b0;
                    i_upd_pc     = addr;
                    i_upd_target = target;
                    i_upd_taken  = taken;
                end else if (op == "Q") begin
                    i_upd_valid = 1'b0;
                    i_query_pc  = addr;
                    @(posedge clk);
                    errs_before = check_errors;
                    check_taken(name, exp_taken, o_pred_taken);
                    check_target(name, exp_target, o_pred_target);
                    report_test(name, errs_before);
                end else begin
                    $display("unknown operation %s in vector %s", op, name);
                    other_errors++;
                end
            end
        end

        if (fd != 0) begin
            if (!$feof(fd)) begin
                $display("vector file not finished after %0d cycles", RUN_TIMEOUT);
                other_errors++;
            end
            $fclose(fd);
        end

        @(negedge clk);
        i_upd_valid = 1'b0;

        $display("tests %0d, passed %0d, failed %0d, other errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, other_errors);
        if (check_errors == 0 && other_errors == 0 && tests_run > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+logic
+incdir+sim
logic/bht_addr_pkg.sv
logic/bht_entry_pkg.sv
logic/bht_update_match.sv
logic/bht_victim_select.sv
logic/bht_entry_table.sv
logic/bht_predict_select.sv
logic/bht_top.sv
sim/bht_tb.sv

/* sim/bht_vectors.txt */
# op name addr target taken exp_taken exp_target, addresses and targets in hex
# U update, I idle cycle with update valid low, Q query and compare the prediction
# after reset nothing predicts
Q rst_q0     000 000 0 0 000
Q rst_q1     abc 000 0 0 000
Q rst_q2     fff 000 0 0 000
# first update allocates weak not taken, second taken update predicts
U a_upd1     100 200 1 0 000
Q a_q1       100 000 0 0 000
U a_upd2     100 200 1 0 000
Q a_q2       100 000 0 1 200
U a_upd3     100 3f0 1 0 000
Q a_q3       100 000 0 1 200
# saturation at strong taken, then strong not taken
U a_upd4     100 200 1 0 000
U a_nt1      100 200 0 0 000
Q a_q4       100 000 0 1 200
U a_nt2      100 200 0 0 000
Q a_q5       100 000 0 0 000
U a_nt3      100 200 0 0 000
U a_nt4      100 200 0 0 000
Q a_q6       100 000 0 0 000
U a_t1       100 200 1 0 000
Q a_q7       100 000 0 0 000
U a_t2       100 200 1 0 000
Q a_q8       100 000 0 1 200
# fill ways 1 to 7 in index order
U fill_b     110 210 1 0 000
U fill_c     120 220 1 0 000
U fill_d     130 230 1 0 000
U fill_e     140 240 1 0 000
U fill_f     150 250 1 0 000
U fill_g     160 260 1 0 000
U fill_h     170 270 1 0 000
Q fill_q_b   110 000 0 0 000
# retrain b, c, e so way 0 becomes the oldest
U b_t1       110 210 1 0 000
Q b_q1       110 000 0 1 210
U c_t1       120 220 1 0 000
U e_t1       140 240 1 0 000
Q a_q9       100 000 0 1 200
U new_i      180 280 1 0 000
Q evict_a    100 000 0 0 000
Q keep_b     110 000 0 1 210
Q keep_c     120 000 0 1 220
Q keep_e     140 000 0 1 240
Q keep_d     130 000 0 0 000
Q new_i_q    180 000 0 0 000
# tenth branch replaces way 3, then trains
U new_j      190 290 1 0 000
U j_t1       190 290 1 0 000
Q j_q        190 000 0 1 290
Q keep_b2    110 000 0 1 210
# idle cycles with junk update fields
Q idle_q0    190 000 0 1 290
I idle1      190 0aa 0 0 000
I idle2      190 0bb 0 0 000
I idle3      555 666 1 0 000
I idle4      100 123 1 0 000
Q idle_q1    190 000 0 1 290
Q idle_q2    555 000 0 0 000
Q idle_q3    100 000 0 0 000
